//--- Bender.yml
package:
  name: apb_delay

dependencies: {}

sources:
  # Shared package
  - common/apb_delay_pkg.sv

  # Design
  - apb_delayer/apb_delayer.sv
  - hw/apb_decoder.sv
  - hw/apb_regbank.sv
  - hw/apb_delay_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verification
    files:
      - verification/apb_delay_tb.sv

//--- apb_delayer/apb_delayer.sv
`default_nettype none

module apb_delayer #(
    parameter int unsigned DELAY_RATIO  = 3584,   // 3.5 in Q.10
    parameter bit          DELAY_ENABLE = 1'b1
) (
    input  wire logic                              clock,
    input  wire logic                              reset,

    input  wire logic [apb_delay_pkg::ADDR_W-1:0]  in_paddr,
    input  wire logic                              in_psel,
    input  wire logic                              in_penable,
    input  wire logic [apb_delay_pkg::PROT_W-1:0]  in_pprot,
    input  wire logic                              in_pwrite,
    input  wire logic [apb_delay_pkg::DATA_W-1:0]  in_pwdata,
    input  wire logic [apb_delay_pkg::STRB_W-1:0]  in_pstrb,
    output      logic                              in_pready,
    output      logic [apb_delay_pkg::DATA_W-1:0]  in_prdata,
    output      logic                              in_pslverr,

    output      logic [apb_delay_pkg::ADDR_W-1:0]  out_paddr,
    output      logic                              out_psel,
    output      logic                              out_penable,
    output      logic [apb_delay_pkg::PROT_W-1:0]  out_pprot,
    output      logic                              out_pwrite,
    output      logic [apb_delay_pkg::DATA_W-1:0]  out_pwdata,
    output      logic [apb_delay_pkg::STRB_W-1:0]  out_pstrb,
    input  wire logic                              out_pready,
    input  wire logic [apb_delay_pkg::DATA_W-1:0]  out_prdata,
    input  wire logic                              out_pslverr
);
    import apb_delay_pkg::*;

    localparam logic [COUNT_W:0] RATIO_C = (COUNT_W + 1)'(DELAY_RATIO);

    delayer_state_e      state_q;
    logic [COUNT_W-1:0]  count_q;
    logic [COUNT_W:0]    count_sum;     // Carry bit exposes overflow
    logic [DATA_W-1:0]   hold_prdata;
    logic                hold_pslverr;
    logic                ready_q;
    logic [DATA_W-1:0]   rdata_q;
    logic                err_q;
    logic                req_open;

    assign count_sum = {1'b0, count_q} + RATIO_C;

    // Device sees nothing once it has answered
    assign req_open = (state_q != HOLD) && !ready_q;

    //////////////////////////////
    // Downstream request
    //////////////////////////////

    assign out_paddr   = in_paddr;
    assign out_pprot   = in_pprot;
    assign out_pwrite  = in_pwrite;
    assign out_pwdata  = in_pwdata;
    assign out_pstrb   = in_pstrb;
    assign out_psel    = in_psel && (req_open || !DELAY_ENABLE);
    assign out_penable = in_penable && (req_open || !DELAY_ENABLE);

    //////////////////////////////
    // Stretch FSM
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (in_psel && !in_penable) begin   // Setup cycle
                        state_q <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    if (out_pready) begin
                        state_q <= HOLD;
                        count_q <= count_q >> RATIO_FRAC_BITS;   // Drop fraction
                    end else begin
                        count_q <= count_sum[COUNT_W-1:0];
                    end
                end
                HOLD: begin
                    if (count_q == '0) begin
                        state_q <= IDLE;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == ACTIVE && out_pready) begin
            hold_prdata  <= out_prdata;
            hold_pslverr <= out_pslverr;
        end
    end

    // One-cycle completion toward the requester
    always_ff @(posedge clock) begin
        if (reset) begin
            ready_q <= 1'b0;
            rdata_q <= '0;
            err_q   <= 1'b0;
        end else if (state_q == HOLD && count_q == '0) begin
            ready_q <= 1'b1;
            rdata_q <= hold_prdata;
            err_q   <= hold_pslverr;
        end else begin
            ready_q <= 1'b0;
            rdata_q <= '0;
            err_q   <= 1'b0;
        end
    end

    assign in_pready  = DELAY_ENABLE ? ready_q : out_pready;
    assign in_prdata  = DELAY_ENABLE ? rdata_q : out_prdata;
    assign in_pslverr = DELAY_ENABLE ? err_q   : out_pslverr;

    //////////////////////////////
    // Checks
    //////////////////////////////

    a_single_ready: assert property (@(posedge clock) disable iff (reset)
        in_pready |=> !in_pready);

    a_enable_in_select: assert property (@(posedge clock) disable iff (reset)
        out_penable |-> out_psel);

    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        (state_q == ACTIVE && !out_pready) |-> !count_sum[COUNT_W]);

endmodule

`default_nettype wire

//--- common/apb_delay_pkg.sv
`default_nettype none

package apb_delay_pkg;

    //////////////////////////////
    // APB bus widths
    //////////////////////////////

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;
    localparam int unsigned PROT_W = 3;

    //////////////////////////////
    // Register bank geometry
    //////////////////////////////

    localparam int unsigned REG_COUNT     = 16;
    localparam int unsigned IDX_W         = $clog2(REG_COUNT);   // Index sits at paddr[5:2]
    localparam int unsigned IDX_LSB       = 2;
    localparam int unsigned BANK_SEL_BIT  = 12;                   // 4 KiB per bank
    localparam int unsigned PRIV_REG_BASE = 8;                    // Upper half needs pprot[0]

    localparam logic [ADDR_W-1:0] MAP_LIMIT = 32'h0000_2000;

    //////////////////////////////
    // Delayer fixed point
    //////////////////////////////

    localparam int unsigned RATIO_FRAC_BITS = 10;
    localparam int unsigned COUNT_W         = 24;

    // Wait stretch sequence of one transfer
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACTIVE = 2'd1,   // Device still waiting
        HOLD   = 2'd2    // Device done, response held back
    } delayer_state_e;

endpackage

`default_nettype wire

//--- filelist.f
+incdir+verification
common/apb_delay_pkg.sv
apb_delayer/apb_delayer.sv
hw/apb_decoder.sv
hw/apb_regbank.sv
hw/apb_delay_top.sv
verification/apb_delay_tb.sv

//--- hw/apb_decoder.sv
`default_nettype none

module apb_decoder (
    input  wire logic [apb_delay_pkg::ADDR_W-1:0]  s_paddr,
    input  wire logic                              s_psel,
    input  wire logic                              s_penable,
    input  wire logic [apb_delay_pkg::PROT_W-1:0]  s_pprot,
    input  wire logic                              s_pwrite,
    input  wire logic [apb_delay_pkg::DATA_W-1:0]  s_pwdata,
    input  wire logic [apb_delay_pkg::STRB_W-1:0]  s_pstrb,
    output      logic                              s_pready,
    output      logic [apb_delay_pkg::DATA_W-1:0]  s_prdata,
    output      logic                              s_pslverr,

    output      logic                              m0_psel,
    output      logic                              m1_psel,
    output      logic [apb_delay_pkg::ADDR_W-1:0]  m_paddr,
    output      logic                              m_penable,
    output      logic [apb_delay_pkg::PROT_W-1:0]  m_pprot,
    output      logic                              m_pwrite,
    output      logic [apb_delay_pkg::DATA_W-1:0]  m_pwdata,
    output      logic [apb_delay_pkg::STRB_W-1:0]  m_pstrb,

    input  wire logic                              m0_pready,
    input  wire logic [apb_delay_pkg::DATA_W-1:0]  m0_prdata,
    input  wire logic                              m0_pslverr,
    input  wire logic                              m1_pready,
    input  wire logic [apb_delay_pkg::DATA_W-1:0]  m1_prdata,
    input  wire logic                              m1_pslverr
);
    import apb_delay_pkg::*;

    logic in_map;
    logic hit_bank1;
    logic access;

    assign in_map    = (s_paddr < MAP_LIMIT);
    assign hit_bank1 = s_paddr[BANK_SEL_BIT];
    assign access    = s_psel && s_penable;

    // Shared request lines, only psel is per bank
    assign m_paddr   = s_paddr;
    assign m_penable = s_penable;
    assign m_pprot   = s_pprot;
    assign m_pwrite  = s_pwrite;
    assign m_pwdata  = s_pwdata;
    assign m_pstrb   = s_pstrb;

    assign m0_psel = s_psel && in_map && !hit_bank1;
    assign m1_psel = s_psel && in_map && hit_bank1;

    always_comb begin
        if (!in_map) begin
            s_pready  = access;   // Zero wait decode error
            s_prdata  = '0;
            s_pslverr = access;
        end else if (hit_bank1) begin
            s_pready  = m1_pready;
            s_prdata  = m1_prdata;
            s_pslverr = m1_pslverr;
        end else begin
            s_pready  = m0_pready;
            s_prdata  = m0_prdata;
            s_pslverr = m0_pslverr;
        end
    end

    always_comb begin
        a_one_hot_sel: assert final (!(m0_psel && m1_psel));
    end

endmodule

`default_nettype wire

//--- hw/apb_delay_top.sv
`default_nettype none

module apb_delay_top #(
    parameter int unsigned DELAY_RATIO  = 3584,
    parameter bit          DELAY_ENABLE = 1'b1,
    parameter int unsigned BANK0_WAIT   = 2,
    parameter int unsigned BANK1_WAIT   = 5
) (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic [apb_delay_pkg::ADDR_W-1:0]  in_paddr,
    input  wire logic                              in_psel,
    input  wire logic                              in_penable,
    input  wire logic [apb_delay_pkg::PROT_W-1:0]  in_pprot,
    input  wire logic                              in_pwrite,
    input  wire logic [apb_delay_pkg::DATA_W-1:0]  in_pwdata,
    input  wire logic [apb_delay_pkg::STRB_W-1:0]  in_pstrb,
    output      logic                              in_pready,
    output      logic [apb_delay_pkg::DATA_W-1:0]  in_prdata,
    output      logic                              in_pslverr
);
    import apb_delay_pkg::*;

    // Delayer to decoder
    logic [ADDR_W-1:0] d_paddr;
    logic              d_psel;
    logic              d_penable;
    logic [PROT_W-1:0] d_pprot;
    logic              d_pwrite;
    logic [DATA_W-1:0] d_pwdata;
    logic [STRB_W-1:0] d_pstrb;
    logic              d_pready;
    logic [DATA_W-1:0] d_prdata;
    logic              d_pslverr;

    // Decoder to banks
    logic [ADDR_W-1:0] m_paddr;
    logic              m_penable;
    logic [PROT_W-1:0] m_pprot;
    logic              m_pwrite;
    logic [DATA_W-1:0] m_pwdata;
    logic [STRB_W-1:0] m_pstrb;
    logic              m0_psel;
    logic              m0_pready;
    logic [DATA_W-1:0] m0_prdata;
    logic              m0_pslverr;
    logic              m1_psel;
    logic              m1_pready;
    logic [DATA_W-1:0] m1_prdata;
    logic              m1_pslverr;

    apb_delayer #(
        .DELAY_RATIO  (DELAY_RATIO),
        .DELAY_ENABLE (DELAY_ENABLE)
    ) delayer_i (
        .clock       (clock),
        .reset       (reset),
        .in_paddr    (in_paddr),
        .in_psel     (in_psel),
        .in_penable  (in_penable),
        .in_pprot    (in_pprot),
        .in_pwrite   (in_pwrite),
        .in_pwdata   (in_pwdata),
        .in_pstrb    (in_pstrb),
        .in_pready   (in_pready),
        .in_prdata   (in_prdata),
        .in_pslverr  (in_pslverr),
        .out_paddr   (d_paddr),
        .out_psel    (d_psel),
        .out_penable (d_penable),
        .out_pprot   (d_pprot),
        .out_pwrite  (d_pwrite),
        .out_pwdata  (d_pwdata),
        .out_pstrb   (d_pstrb),
        .out_pready  (d_pready),
        .out_prdata  (d_prdata),
        .out_pslverr (d_pslverr)
    );

    apb_decoder decoder_i (
        .s_paddr    (d_paddr),
        .s_psel     (d_psel),
        .s_penable  (d_penable),
        .s_pprot    (d_pprot),
        .s_pwrite   (d_pwrite),
        .s_pwdata   (d_pwdata),
        .s_pstrb    (d_pstrb),
        .s_pready   (d_pready),
        .s_prdata   (d_prdata),
        .s_pslverr  (d_pslverr),
        .m0_psel    (m0_psel),
        .m1_psel    (m1_psel),
        .m_paddr    (m_paddr),
        .m_penable  (m_penable),
        .m_pprot    (m_pprot),
        .m_pwrite   (m_pwrite),
        .m_pwdata   (m_pwdata),
        .m_pstrb    (m_pstrb),
        .m0_pready  (m0_pready),
        .m0_prdata  (m0_prdata),
        .m0_pslverr (m0_pslverr),
        .m1_pready  (m1_pready),
        .m1_prdata  (m1_prdata),
        .m1_pslverr (m1_pslverr)
    );

    apb_regbank #(
        .WAIT (BANK0_WAIT)
    ) bank0_i (
        .clock   (clock),
        .reset   (reset),
        .paddr   (m_paddr),
        .psel    (m0_psel),
        .penable (m_penable),
        .pprot   (m_pprot),
        .pwrite  (m_pwrite),
        .pwdata  (m_pwdata),
        .pstrb   (m_pstrb),
        .pready  (m0_pready),
        .prdata  (m0_prdata),
        .pslverr (m0_pslverr)
    );

    apb_regbank #(
        .WAIT (BANK1_WAIT)
    ) bank1_i (
        .clock   (clock),
        .reset   (reset),
        .paddr   (m_paddr),
        .psel    (m1_psel),
        .penable (m_penable),
        .pprot   (m_pprot),
        .pwrite  (m_pwrite),
        .pwdata  (m_pwdata),
        .pstrb   (m_pstrb),
        .pready  (m1_pready),
        .prdata  (m1_prdata),
        .pslverr (m1_pslverr)
    );

endmodule

`default_nettype wire

//--- hw/apb_regbank.sv
`default_nettype none

module apb_regbank #(
    parameter int unsigned WAIT = 2
) (
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic [apb_delay_pkg::ADDR_W-1:0]  paddr,
    input  wire logic                              psel,
    input  wire logic                              penable,
    input  wire logic [apb_delay_pkg::PROT_W-1:0]  pprot,
    input  wire logic                              pwrite,
    input  wire logic [apb_delay_pkg::DATA_W-1:0]  pwdata,
    input  wire logic [apb_delay_pkg::STRB_W-1:0]  pstrb,
    output      logic                              pready,
    output      logic [apb_delay_pkg::DATA_W-1:0]  prdata,
    output      logic                              pslverr
);
    import apb_delay_pkg::*;

    localparam int unsigned CNT_W = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

    logic [DATA_W-1:0] regs [REG_COUNT];
    logic [IDX_W-1:0]  idx;
    logic              bad_offset;
    logic              bad_priv;
    logic              err;
    logic              setup;
    logic              access;
    logic              raise;
    logic [CNT_W-1:0]  cnt_q;
    logic              pready_q;
    logic [DATA_W-1:0] prdata_q;
    logic              pslverr_q;

    //////////////////////////////
    // Access decode
    //////////////////////////////

    assign idx = paddr[IDX_LSB +: IDX_W];

    // Only the index bits may be set inside the bank window
    assign bad_offset = (paddr[BANK_SEL_BIT-1:IDX_LSB+IDX_W] != '0)
                     || (paddr[IDX_LSB-1:0] != '0);
    assign bad_priv   = (idx >= IDX_W'(PRIV_REG_BASE)) && !pprot[0];
    assign err        = bad_offset || bad_priv;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // Response goes out WAIT access cycles after the setup cycle
    assign raise = (setup && WAIT == 0)
                || (access && !pready_q && cnt_q == CNT_W'(1));

    //////////////////////////////
    // Wait counter and response
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            cnt_q     <= '0;
            pready_q  <= 1'b0;
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else if (pready_q) begin   // Transfer ends this cycle
            pready_q  <= 1'b0;
            prdata_q  <= '0;
            pslverr_q <= 1'b0;
        end else begin
            if (setup) begin
                cnt_q <= CNT_W'(WAIT);
            end else if (access && cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end
            if (raise) begin
                pready_q  <= 1'b1;
                prdata_q  <= (err || pwrite) ? '0 : regs[idx];
                pslverr_q <= err;
            end
        end
    end

    // Byte-wise write, blocked on error
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else if (raise && pwrite && !err) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (pstrb[b]) begin
                    regs[idx][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

    assign pready  = pready_q;
    assign prdata  = prdata_q;
    assign pslverr = pslverr_q;

    a_ready_in_access: assert property (@(posedge clock) disable iff (reset)
        pready |-> (psel && penable));

endmodule

`default_nettype wire

//--- verification/apb_delay_ref.svh
`ifndef APB_DELAY_REF_SVH
`define APB_DELAY_REF_SVH

//////////////////////////////
// Register file shadow
//////////////////////////////

logic [31:0] shadow [32];   // Bank 1 starts at slot 16

function automatic logic [31:0] reg_address(input int unsigned r);
    return (r / 16) * 32'h1000 + (r % 16) * 4;
endfunction

function automatic void clear_shadow();
    for (int i = 0; i < 32; i++) begin
        shadow[i] = '0;
    end
endfunction

// Shadow slot of an address, or -1 when it is out of the map or badly aligned
function automatic int reg_slot(input logic [31:0] addr);
    if (addr >= 32'h2000 || addr[11:6] != 6'd0 || addr[1:0] != 2'd0) begin
        return -1;
    end
    return int'(addr[12]) * 16 + int'(addr[5:2]);
endfunction

function automatic void predict_access(input logic [31:0] addr, input logic write,
        input logic [31:0] wdata, input logic [3:0] strb, input logic [2:0] prot,
        output logic [31:0] data, output logic err);
    int slot;
    slot = reg_slot(addr);
    data = '0;
    err  = (slot < 0) || ((slot % 16) >= 8 && !prot[0]);   // Upper half is privileged
    if (!err && write) begin
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                shadow[slot][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end else if (!err) begin
        data = shadow[slot];
    end
endfunction

// Access cycle in which the upstream completion shows up
function automatic int expected_latency(input logic [31:0] addr);
    int unsigned n;
    if (addr >= 32'h2000) begin
        n = 0;   // Decoder answers at once
    end else if (addr[12]) begin
        n = BANK1_WAIT;
    end else begin
        n = BANK0_WAIT;
    end
    return int'(n + (n * DELAY_RATIO) / 1024 + 2);
endfunction

`endif

//--- verification/apb_delay_tb.sv
`default_nettype none

module apb_delay_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned DELAY_RATIO = 3584;   // 3.5
    localparam int unsigned BANK0_WAIT  = 2;
    localparam int unsigned BANK1_WAIT  = 5;
    localparam int          TIMEOUT     = 100;

    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [2:0]  prot;
        int          latency;
        logic [31:0] rdata;
        logic        err;
    } xfer_t;

    logic        clock;
    logic        reset;
    logic [31:0] in_paddr;
    logic        in_psel;
    logic        in_penable;
    logic [2:0]  in_pprot;
    logic        in_pwrite;
    logic [31:0] in_pwdata;
    logic [3:0]  in_pstrb;
    logic        in_pready;
    logic [31:0] in_prdata;
    logic        in_pslverr;

    xfer_t done_q [$];   // Completed transfers waiting for comparison
    int    error_count;
    int    xfer_count;
    bit    aborted;
    bit    prev_ready;

    `include "apb_delay_ref.svh"

    apb_delay_top #(
        .DELAY_RATIO  (DELAY_RATIO),
        .DELAY_ENABLE (1'b1),
        .BANK0_WAIT   (BANK0_WAIT),
        .BANK1_WAIT   (BANK1_WAIT)
    ) dut_i (
        .clock      (clock),
        .reset      (reset),
        .in_paddr   (in_paddr),
        .in_psel    (in_psel),
        .in_penable (in_penable),
        .in_pprot   (in_pprot),
        .in_pwrite  (in_pwrite),
        .in_pwdata  (in_pwdata),
        .in_pstrb   (in_pstrb),
        .in_pready  (in_pready),
        .in_prdata  (in_prdata),
        .in_pslverr (in_pslverr)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    //////////////////////////////
    // APB requester
    //////////////////////////////

    task automatic apb_transfer(input logic [31:0] addr, input logic write,
            input logic [31:0] wdata, input logic [3:0] strb, input logic [2:0] prot);
        xfer_t t;
        int    cycles;
        if (aborted) begin
            return;
        end
        @(negedge clock);   // Setup cycle
        in_paddr   = addr;
        in_psel    = 1'b1;
        in_penable = 1'b0;
        in_pwrite  = write;
        in_pwdata  = wdata;
        in_pstrb   = strb;
        in_pprot   = prot;
        @(negedge clock);
        in_penable = 1'b1;
        cycles     = 0;   // Access cycle 0
        while (in_pready !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (in_pready !== 1'b1) begin
            $display("Timeout: no pready within %0d cycles for address %h at %0t",
                     TIMEOUT, addr, $time);
            error_count++;
            aborted = 1'b1;
        end else begin
            t = '{addr, write, wdata, strb, prot, cycles, in_prdata, in_pslverr};
            done_q.push_back(t);
        end
    endtask

    //////////////////////////////
    // Comparison
    //////////////////////////////

    task automatic check_transfer(input xfer_t t);
        logic [31:0] exp_data;
        logic        exp_err;
        int          exp_lat;
        predict_access(t.addr, t.write, t.wdata, t.strb, t.prot, exp_data, exp_err);
        exp_lat = expected_latency(t.addr);
        xfer_count++;
        assert (t.latency == exp_lat) else begin
            error_count++;
            $display("FAILED %0t: addr %h done in access cycle %0d, expected %0d",
                     $time, t.addr, t.latency, exp_lat);
        end
        assert (t.err === exp_err) else begin
            error_count++;
            $display("FAILED %0t: addr %h pslverr %b, expected %b",
                     $time, t.addr, t.err, exp_err);
        end
        if (!t.write || exp_err) begin
            assert (t.rdata === exp_data) else begin
                error_count++;
                $display("FAILED %0t: addr %h prdata %h, expected %h",
                         $time, t.addr, t.rdata, exp_data);
            end
        end
    endtask

    initial begin : compare
        prev_ready = 1'b0;
        forever begin
            @(negedge clock);
            if (!reset) begin
                assert (!(prev_ready && in_pready)) else begin
                    error_count++;
                    $display("FAILED %0t: in_pready high for two cycles", $time);
                end
            end
            prev_ready = in_pready;
            while (done_q.size() > 0) begin
                check_transfer(done_q.pop_front());
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        logic [31:0] addr;
        int unsigned pick;
        int          cycles;
        void'($urandom(32'h6a56e2a0));
        reset       = 1'b1;
        in_paddr    = '0;
        in_psel     = 1'b0;
        in_penable  = 1'b0;
        in_pprot    = '0;
        in_pwrite   = 1'b0;
        in_pwdata   = '0;
        in_pstrb    = '0;
        error_count = 0;
        xfer_count  = 0;
        aborted     = 1'b0;
        clear_shadow();
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int r = 0; r < 32; r++) begin   // Reset values
            apb_transfer(reg_address(r), 1'b0, '0, '0, 3'b001);
        end
        for (int r = 0; r < 32; r++) begin   // Partial writes
            apb_transfer(reg_address(r), 1'b1, $urandom, 4'($urandom), 3'b001);
        end
        for (int r = 0; r < 32; r++) begin
            apb_transfer(reg_address(r), 1'b0, '0, '0, 3'b001);
        end

        // Privileged registers
        apb_transfer(reg_address(9), 1'b1, 32'hdead_beef, 4'hf, 3'b000);
        apb_transfer(reg_address(9), 1'b0, '0, '0, 3'b001);
        apb_transfer(reg_address(9), 1'b1, 32'hdead_beef, 4'hf, 3'b011);
        apb_transfer(reg_address(9), 1'b0, '0, '0, 3'b001);
        apb_transfer(reg_address(28), 1'b0, '0, '0, 3'b110);

        // Decode and offset errors
        apb_transfer(32'h0000_2000, 1'b0, '0, '0, 3'b001);
        apb_transfer(32'h0001_0000, 1'b0, '0, '0, 3'b001);
        apb_transfer(32'hffff_fffc, 1'b0, '0, '0, 3'b001);
        apb_transfer(32'h0000_2004, 1'b1, 32'h1234_5678, 4'hf, 3'b001);
        apb_transfer(32'h0000_0040, 1'b0, '0, '0, 3'b001);
        apb_transfer(32'h0000_1001, 1'b0, '0, '0, 3'b001);
        apb_transfer(32'h0000_0802, 1'b0, '0, '0, 3'b001);
        apb_transfer(32'h0000_1080, 1'b1, 32'h0bad_f00d, 4'hf, 3'b001);

        for (int i = 0; i < 200; i++) begin
            pick = $urandom_range(15, 0);
            addr = reg_address($urandom_range(31, 0));
            if (pick == 0) begin
                addr = 32'h0000_2000 + {$urandom_range(1023, 0), 2'b00};
            end else if (pick == 1) begin
                addr = addr | 32'h0000_0040;   // Stray offset bit
            end
            apb_transfer(addr, 1'($urandom), $urandom, 4'($urandom), 3'($urandom));
        end

        @(negedge clock);
        in_psel    = 1'b0;
        in_penable = 1'b0;
        cycles     = 0;
        while (done_q.size() != 0 && cycles < 10) begin
            @(negedge clock);
            cycles++;
        end
        if (done_q.size() != 0) begin
            $display("Comparison queue still holds %0d transfers at the end", done_q.size());
            error_count++;
        end
        $display("Checked %0d transfers, %0d errors", xfer_count, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
